// File: design/vecmat_macros.svh
`ifndef VECMAT_MACROS_SVH
`define VECMAT_MACROS_SVH

// ====================
// Datapath geometry
// ====================

// Elements per chunk
`define VM_LANES 32

// Signed Q7.8 element
`define VM_DATA_W 16
`define VM_FRAC 8

`endif

// File: design/vecmat_pkg.sv
`include "vecmat_macros.svh"

package vecmat_pkg;

	// ====================
	// Types
	// ====================

	// One signed Q7.8 element
	typedef logic signed [`VM_DATA_W-1:0] lane_t;

	// Lane 0 sits in the low bits
	typedef lane_t [`VM_LANES-1:0] lane_vec_t;

	// Full-precision product of two lanes
	typedef logic signed [2*`VM_DATA_W-1:0] prod_t;

	// Control travelling with each chunk
	typedef struct packed {
		logic go;
		logic last;
	} stage_ctl_t;

	// Saturation limits
	localparam lane_t LANE_MAX = {1'b0, {(`VM_DATA_W-1){1'b1}}};
	localparam lane_t LANE_MIN = {1'b1, {(`VM_DATA_W-1){1'b0}}};

	// ====================
	// Arithmetic
	// ====================

	// Q7.8 multiply, truncate the low fraction bits, then clamp
	function automatic lane_t sat_mul(input lane_t a, input lane_t b);
		prod_t prod;
		logic [`VM_DATA_W-`VM_FRAC:0] head;
		lane_t res;

		prod = prod_t'(a) * prod_t'(b);
		// Bits above the kept window must all match its sign bit
		head = prod[2*`VM_DATA_W-1:`VM_DATA_W+`VM_FRAC-1];
		if (head == '0 || head == '1) begin
			res = prod[`VM_DATA_W+`VM_FRAC-1:`VM_FRAC];
		end else if (prod[2*`VM_DATA_W-1]) begin
			res = LANE_MIN;
		end else begin
			res = LANE_MAX;
		end
		return res;
	endfunction

	// Add with one guard bit, clamp on overflow
	function automatic lane_t sat_add(input lane_t a, input lane_t b);
		logic signed [`VM_DATA_W:0] s;
		lane_t res;

		s = (`VM_DATA_W+1)'(a) + (`VM_DATA_W+1)'(b);
		if (s[`VM_DATA_W] == s[`VM_DATA_W-1]) begin
			res = s[`VM_DATA_W-1:0];
		end else if (s[`VM_DATA_W]) begin
			res = LANE_MIN;
		end else begin
			res = LANE_MAX;
		end
		return res;
	endfunction

endpackage

// File: design/vecmat_mul_32.sv
`include "vecmat_macros.svh"

module vecmat_mul_32 (
	input logic clk,
	input logic reset,
	input vecmat_pkg::lane_vec_t vector,
	input vecmat_pkg::lane_vec_t matrix,
	input vecmat_pkg::stage_ctl_t ctl_in,
	output vecmat_pkg::lane_vec_t product,
	output vecmat_pkg::stage_ctl_t ctl_out
);

	import vecmat_pkg::*;

	// ====================
	// Lane multipliers
	// ====================

	// Every lane runs each cycle, valid or not
	genvar i;
	generate
		for (i = 0; i < `VM_LANES; i++) begin : g_lane
			always_ff @(posedge clk) begin
				product[i] <= sat_mul(vector[i], matrix[i]);
			end
		end
	endgenerate

	// ====================
	// Control
	// ====================

	// Follows the products by one edge
	always_ff @(posedge clk) begin
		if (!reset) begin
			ctl_out <= '0;
		end else begin
			ctl_out <= ctl_in;
		end
	end

endmodule

// File: design/vecmat_add_32.sv
`include "vecmat_macros.svh"

module vecmat_add_32 (
	input logic clk,
	input logic reset,
	input vecmat_pkg::lane_vec_t product,
	input vecmat_pkg::stage_ctl_t ctl_in,
	output vecmat_pkg::lane_t sum,
	output vecmat_pkg::stage_ctl_t ctl_out
);

	import vecmat_pkg::*;

	localparam int L1_N = `VM_LANES / 2;
	localparam int L2_N = `VM_LANES / 4;
	localparam int L3_N = `VM_LANES / 8;
	localparam int L4_N = `VM_LANES / 16;

	lane_t lvl1 [L1_N];
	lane_t lvl2 [L2_N];
	lane_t lvl2_q [L2_N];
	lane_t lvl3 [L3_N];
	lane_t lvl4 [L4_N];
	lane_t lvl5;
	stage_ctl_t ctl_mid;

	// ====================
	// Levels 1 and 2
	// ====================

	// Adjacent pairs, so lane 2j meets lane 2j+1
	genvar j;
	generate
		for (j = 0; j < L1_N; j++) begin : g_lvl1
			assign lvl1[j] = sat_add(product[2*j], product[2*j+1]);
		end
		for (j = 0; j < L2_N; j++) begin : g_lvl2
			assign lvl2[j] = sat_add(lvl1[2*j], lvl1[2*j+1]);
		end
	endgenerate

	// Mid-tree register
	always_ff @(posedge clk) begin
		for (int k = 0; k < L2_N; k++) begin
			lvl2_q[k] <= lvl2[k];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			ctl_mid <= '0;
		end else begin
			ctl_mid <= ctl_in;
		end
	end

	// ====================
	// Levels 3 to 5
	// ====================

	generate
		for (j = 0; j < L3_N; j++) begin : g_lvl3
			assign lvl3[j] = sat_add(lvl2_q[2*j], lvl2_q[2*j+1]);
		end
		for (j = 0; j < L4_N; j++) begin : g_lvl4
			assign lvl4[j] = sat_add(lvl3[2*j], lvl3[2*j+1]);
		end
	endgenerate

	assign lvl5 = sat_add(lvl4[0], lvl4[1]);

	// Tree output register
	always_ff @(posedge clk) begin
		sum <= lvl5;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			ctl_out <= '0;
		end else begin
			ctl_out <= ctl_mid;
		end
	end

endmodule

// File: design/vecmat_acc.sv
module vecmat_acc (
	input logic clk,
	input logic reset,
	input vecmat_pkg::lane_t sum,
	input vecmat_pkg::stage_ctl_t ctl_in,
	output vecmat_pkg::lane_t data_out,
	output logic done
);

	import vecmat_pkg::*;

	// Sum of the chunks seen so far in this dot product
	lane_t running;
	lane_t total;

	// ====================
	// Accumulate
	// ====================

	// Includes the chunk arriving now
	assign total = sat_add(running, sum);

	always_ff @(posedge clk) begin
		if (!reset) begin
			running <= '0;
		end else if (ctl_in.go) begin
			// Last chunk closes the row, next row starts from zero
			if (ctl_in.last) begin
				running <= '0;
			end else begin
				running <= total;
			end
		end
	end

	// ====================
	// Result
	// ====================

	// Holds until the next completed row
	always_ff @(posedge clk) begin
		if (!reset) begin
			data_out <= '0;
		end else if (ctl_in.go && ctl_in.last) begin
			data_out <= total;
		end
	end

	// One-cycle strobe with the new data_out
	always_ff @(posedge clk) begin
		if (!reset) begin
			done <= 1'b0;
		end else begin
			done <= ctl_in.go & ctl_in.last;
		end
	end

endmodule

// File: design/vecmat32_dsp.sv
module vecmat32_dsp (
	input logic clk,
	input logic reset,
	input vecmat_pkg::lane_vec_t vector,
	input vecmat_pkg::lane_vec_t matrix,
	input logic go,
	input logic last,
	output vecmat_pkg::lane_t data_out,
	output logic done
);

	import vecmat_pkg::*;

	stage_ctl_t ctl_in;
	stage_ctl_t ctl_mul;
	stage_ctl_t ctl_add;
	lane_vec_t product;
	lane_t partial;

	// last only matters together with go
	assign ctl_in.go = go;
	assign ctl_in.last = last;

	// ====================
	// Pipeline
	// ====================

	// Products registered at E
	vecmat_mul_32 i_mul (
		.clk(clk),
		.reset(reset),
		.vector(vector),
		.matrix(matrix),
		.ctl_in(ctl_in),
		.product(product),
		.ctl_out(ctl_mul)
	);

	// Mid-tree at E+1, chunk sum at E+2
	vecmat_add_32 i_add (
		.clk(clk),
		.reset(reset),
		.product(product),
		.ctl_in(ctl_mul),
		.sum(partial),
		.ctl_out(ctl_add)
	);

	// Running sum and result at E+3
	vecmat_acc i_acc (
		.clk(clk),
		.reset(reset),
		.sum(partial),
		.ctl_in(ctl_add),
		.data_out(data_out),
		.done(done)
	);

endmodule

// File: tests/vecmat_clkgen.sv
module vecmat_clkgen (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Low for the first 8 rising edges
	initial begin
		reset = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b1;
	end

endmodule

// File: tests/vecmat_assert.sv
module vecmat_assert (
	input logic clk,
	input logic reset,
	input logic go,
	input logic last,
	input logic done
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertion count
	int fail_count = 0;

	// ====================
	// Reset
	// ====================

	reset_clears_done: assert property (@(posedge clk) !reset |=> !done)
		else begin
			$error("done still high one cycle after a reset edge");
			fail_count++;
		end

	// ====================
	// Result timing
	// ====================

	// Four edges from the sampling of go to the sampled done
	last_gives_done: assert property (@(posedge clk) disable iff (!reset)
		$past(go && last, 4) |-> done)
		else begin
			$error("no done four edges after a last chunk");
			fail_count++;
		end

	plain_chunk_no_done: assert property (@(posedge clk) disable iff (!reset)
		$past(go && !last, 4) |-> !done)
		else begin
			$error("done after a chunk without last");
			fail_count++;
		end

	// Back to back only for back to back last chunks
	done_one_cycle: assert property (@(posedge clk) disable iff (!reset)
		(done && $past(done)) |-> ($past(go && last, 4) && $past(go && last, 5)))
		else begin
			$error("done held for two cycles without two last chunks");
			fail_count++;
		end

endmodule

// File: tests/tb_vecmat.sv
`include "vecmat_macros.svh"

module tb_vecmat;

	timeunit 1ns;
	timeprecision 1ps;

	import vecmat_pkg::*;

	localparam int N_PIPE = 40;
	localparam int N_GAP_ROWS = 6;
	localparam int CHUNKS = 1 + 3 + 3 + N_PIPE + 8 + 2 * N_GAP_ROWS;
	localparam int GAP_CYCLES = 2 * N_GAP_ROWS * 3;
	localparam int LIMIT_CYCLES = CHUNKS + GAP_CYCLES + 6 * 10 + 8 + 20;

	logic clk;
	logic reset;
	lane_vec_t vector;
	lane_vec_t matrix;
	logic go;
	logic last;
	lane_t data_out;
	logic done;

	int seed;
	lane_t expect_q[$];
	lane_t model_running = '0;
	lane_t expected;
	int errors = 0;
	int done_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	vecmat_clkgen i_clkgen (
		.clk(clk),
		.reset(reset)
	);

	vecmat32_dsp i_vecmat32_dsp (
		.clk(clk),
		.reset(reset),
		.vector(vector),
		.matrix(matrix),
		.go(go),
		.last(last),
		.data_out(data_out),
		.done(done)
	);

	bind vecmat32_dsp vecmat_assert i_vecmat_assert (
		.clk(clk),
		.reset(reset),
		.go(go),
		.last(last),
		.done(done)
	);

	// ====================
	// Reference model
	// ====================

	// Products, then adjacent pairs level by level
	function automatic lane_t chunk_sum(input lane_vec_t v, input lane_vec_t m);
		lane_t level [`VM_LANES];
		int n;
		for (int i = 0; i < `VM_LANES; i++) begin
			level[i] = sat_mul(v[i], m[i]);
		end
		n = `VM_LANES;
		while (n > 1) begin
			for (int i = 0; i < n / 2; i++) begin
				level[i] = sat_add(level[2*i], level[2*i+1]);
			end
			n = n / 2;
		end
		return level[0];
	endfunction

	// Immediate check errors plus concurrent assertion failures
	function automatic int error_total();
		return errors + i_vecmat32_dsp.i_vecmat_assert.fail_count;
	endfunction

	// ====================
	// Drivers
	// ====================

	task automatic send_chunk(input lane_vec_t v, input lane_vec_t m, input logic is_last);
		@(posedge clk);
		vector <= v;
		matrix <= m;
		go <= 1'b1;
		last <= is_last;
		model_running = sat_add(model_running, chunk_sum(v, m));
		if (is_last) begin
			expect_q.push_back(model_running);
			model_running = '0;
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			go <= 1'b0;
			last <= 1'b0;
		end
	endtask

	task automatic random_vec(input int range, output lane_vec_t v);
		for (int i = 0; i < `VM_LANES; i++) begin
			v[i] = lane_t'($random(seed) % range);
		end
	endtask

	task automatic drain();
		idle(1);
		while (expect_q.size() != 0) begin
			@(negedge clk);
		end
		// Room for the last assertion window
		idle(4);
	endtask

	task automatic end_test(input string name, input int errs_at_start,
		input int dones_at_start, input int dones_wanted);
		int dones_seen;
		dones_seen = done_count - dones_at_start;
		if (dones_seen != dones_wanted) begin
			$display("%s saw %0d done pulses instead of %0d", name, dones_seen, dones_wanted);
			errors++;
		end
		if (error_total() == errs_at_start) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, error_total() - errs_at_start);
		end
	endtask

	// ====================
	// Result checker
	// ====================

	always @(negedge clk) begin
		if (reset && done) begin
			done_count++;
			if (expect_q.size() == 0) begin
				$display("Got a done pulse with no result expected");
				errors++;
			end else begin
				expected = expect_q.pop_front();
				assert (data_out == expected) else begin
					$display("[FAIL] data_out expected %h got %h", expected, data_out);
					errors++;
				end
			end
		end
	end

	// ====================
	// Tests
	// ====================

	task automatic check_reset();
		int errs_at_start;
		int dones_at_start;
		errs_at_start = error_total();
		dones_at_start = done_count;
		@(posedge clk);
		// Through reset and two idle cycles after it
		repeat (10) begin
			@(negedge clk);
			assert (done == 1'b0) else begin
				$display("[FAIL] done expected 0 got %h", done);
				errors++;
			end
			assert (data_out == '0) else begin
				$display("[FAIL] data_out expected 0000 got %h", data_out);
				errors++;
			end
		end
		end_test("reset", errs_at_start, dones_at_start, 0);
	endtask

	task automatic run_rows(input string name, input int kind);
		int errs_at_start;
		int dones_at_start;
		int rows;
		int n_chunks;
		int gap;
		lane_vec_t v;
		lane_vec_t m;
		errs_at_start = error_total();
		dones_at_start = done_count;
		rows = 0;
		case (kind)
			0: begin
				// Quarter steps times 0.5, exact sum 62.0
				for (int i = 0; i < `VM_LANES; i++) begin
					v[i] = lane_t'(i * 64);
					m[i] = 16'h0080;
				end
				send_chunk(v, m, 1'b1);
				expect_q[expect_q.size() - 1] = 16'h3e00;
				rows = 1;
			end
			1: begin
				for (int c = 0; c < 3; c++) begin
					random_vec(256, v);
					random_vec(256, m);
					send_chunk(v, m, c == 2);
				end
				rows = 1;
			end
			2: begin
				send_chunk({`VM_LANES{16'h7fff}}, {`VM_LANES{16'h7fff}}, 1'b1);
				send_chunk({`VM_LANES{16'h9000}}, {`VM_LANES{16'h0200}}, 1'b1);
				// Exact -128 on even lanes, clamped -336 on odd lanes
				send_chunk({(`VM_LANES / 2){16'h9000, 16'h8000}},
					{(`VM_LANES / 2){16'h0300, 16'h0100}}, 1'b1);
				rows = 3;
			end
			3: begin
				for (int r = 0; r < N_PIPE; r++) begin
					n_chunks = (r % 10 == 9) ? 3 : 1;
					for (int c = 0; c < n_chunks; c++) begin
						random_vec(512, v);
						random_vec(512, m);
						send_chunk(v, m, c == n_chunks - 1);
					end
				end
				rows = N_PIPE;
			end
			default: begin
				for (int r = 0; r < N_GAP_ROWS; r++) begin
					for (int c = 0; c < 2; c++) begin
						random_vec(512, v);
						random_vec(512, m);
						gap = $unsigned($random(seed)) % 4;
						idle(gap);
						send_chunk(v, m, c == 1);
					end
				end
				rows = N_GAP_ROWS;
			end
		endcase
		drain();
		end_test(name, errs_at_start, dones_at_start, rows);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		seed = 32'hfc40384f;
		go <= 1'b0;
		last <= 1'b0;
		vector <= '0;
		matrix <= '0;
		check_reset();
		run_rows("single chunk", 0);
		run_rows("multi chunk", 1);
		run_rows("saturation", 2);
		run_rows("pipelining", 3);
		run_rows("idle gaps", 4);
		$display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
		if (tests_failed == 0 && error_total() == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Cycle budget covers every chunk, gap and drain
	initial begin
		#(LIMIT_CYCLES * 10);
		$display("Simulation timed out after %0d cycles", LIMIT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+design
design/vecmat_pkg.sv
design/vecmat_mul_32.sv
design/vecmat_add_32.sv
design/vecmat_acc.sv
design/vecmat32_dsp.sv
tests/vecmat_clkgen.sv
tests/vecmat_assert.sv
tests/tb_vecmat.sv

// File: Makefile
SRCS := $(wildcard design/*.sv design/*.svh tests/*.sv)

all: run

obj_dir/Vtb_vecmat: verilog.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_vecmat -f verilog.f

run: obj_dir/Vtb_vecmat
	./obj_dir/Vtb_vecmat 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
